// File: logic/i8080_defines.svh
// i8080 ALU constants
// data width, PSW flag bit positions and the PSW value after reset
`ifndef I8080_DEFINES_SVH
`define I8080_DEFINES_SVH

`define I8080_DATA_W      8

// PSW byte layout is S Z 0 AC 0 P 1 CY
`define I8080_PSW_S       7
`define I8080_PSW_Z       6
`define I8080_PSW_AC      4
`define I8080_PSW_P       2
`define I8080_PSW_CY      0

// only the fixed bit 1 is set after reset
`define I8080_PSW_RESET   8'h02

`endif

// File: logic/i8080_isa_pkg.sv
// i8080 instruction set types
// ALU operation codes for the kept opcodes and the decoded operation
// that passes from the decode stage to the execute stage
`include "i8080_defines.svh"

package i8080_isa_pkg;

   // low three bits follow the ooo field of the opcode,
   // bit 3 selects the 00ooo111 accumulator group
   typedef enum logic [4:0] {
      OP_ADD  = 5'h00,
      OP_ADC  = 5'h01,
      OP_SUB  = 5'h02,
      OP_SBB  = 5'h03,
      OP_ANA  = 5'h04,
      OP_XRA  = 5'h05,
      OP_ORA  = 5'h06,
      OP_CMP  = 5'h07,
      OP_RLC  = 5'h08,
      OP_RRC  = 5'h09,
      OP_RAL  = 5'h0a,
      OP_RAR  = 5'h0b,
      OP_DAA  = 5'h0c,
      OP_CMA  = 5'h0d,
      OP_STC  = 5'h0e,
      OP_CMC  = 5'h0f,
      OP_NONE = 5'h10
   } alu_op_e;

   // operation with the operand byte from the register file or immediate
   typedef struct packed {
      alu_op_e                  op;
      logic [`I8080_DATA_W-1:0] operand;
      logic                     valid;
   } decoded_op_t;

endpackage

// File: logic/i8080_datapath_pkg.sv
// i8080 datapath types
// flag word with its two views, the architectural accumulator and PSW,
// and the raw result handed from execute to flag commit
`include "i8080_defines.svh"

package i8080_datapath_pkg;

   // flag fields in PSW bit order, most significant first
   typedef struct packed {
      logic s;
      logic z;
      logic zero5;
      logic ac;
      logic zero3;
      logic p;
      logic one1;
      logic cy;
   } psw_fields_t;

   // stored by flag name, read out as the PSW byte
   typedef union packed {
      psw_fields_t              f;
      logic [`I8080_DATA_W-1:0] raw;
   } psw_u;

   typedef struct packed {
      logic [`I8080_DATA_W-1:0] acc;
      psw_u                     psw;
   } arch_state_t;

   typedef struct packed {
      i8080_isa_pkg::alu_op_e   op;
      logic [`I8080_DATA_W-1:0] sum;
      logic                     carry7;
      logic                     carry3;
      logic                     x3;
      logic                     r3;
      logic                     valid;
   } exec_result_t;

endpackage

// File: logic/alu_decode.sv
// i8080 ALU decode stage
// classifies the opcode byte into an ALU operation and registers it
// together with the operand byte and the valid strobe
`timescale 1ns/1ps
`include "i8080_defines.svh"

module alu_decode
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       op_valid,
   input  logic [`I8080_DATA_W-1:0]   opcode,
   input  logic [`I8080_DATA_W-1:0]   operand,
   output i8080_isa_pkg::decoded_op_t dec
);

   import i8080_isa_pkg::*;

   alu_op_e    op_d;
   logic [2:0] grp;

   // ooo field selects the operation within each group
   assign grp = opcode[5:3];

   always_comb
   begin
      casez (opcode)
         // register form 10ooosss and immediate form 11ooo110
         8'b10??_????,
         8'b11??_?110:
         begin
            op_d = alu_op_e'({2'b00, grp});
         end
         // rotates, DAA, CMA, STC, CMC
         8'b00??_?111:
         begin
            op_d = alu_op_e'({2'b01, grp});
         end
         // anything else passes through and leaves the state alone
         default:
         begin
            op_d = OP_NONE;
         end
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         dec.op      <= OP_NONE;
         dec.operand <= '0;
         dec.valid   <= 1'b0;
      end
      else
      begin
         dec.op      <= op_d;
         dec.operand <= operand;
         dec.valid   <= op_valid;
      end
   end

endmodule

// File: logic/alu_execute.sv
// i8080 ALU execute stage
// operand inverter, ripple adder with bit 3 and bit 7 carries, logic ops,
// rotator and DAA correction; accumulator and flags come forwarded from
// the commit stage
`timescale 1ns/1ps
`include "i8080_defines.svh"

module alu_execute
(
   input  logic                             clk,
   input  logic                             reset,
   input  i8080_isa_pkg::decoded_op_t       dec,
   input  i8080_datapath_pkg::arch_state_t  state_next,
   output i8080_datapath_pkg::exec_result_t ex
);

   import i8080_isa_pkg::*;
   import i8080_datapath_pkg::*;

   logic [`I8080_DATA_W-1:0] acc;
   logic [`I8080_DATA_W-1:0] b_in;
   logic [`I8080_DATA_W-1:0] add_sum;
   logic [`I8080_DATA_W-1:0] res;
   logic [`I8080_DATA_W-1:0] daa_corr;
   logic [`I8080_DATA_W:0]   chain;
   logic                     cy;
   logic                     ac;
   logic                     cin;
   logic                     lo_fix;
   logic                     hi_fix;
   logic                     carry_out;

   assign acc = state_next.acc;
   assign cy  = state_next.psw.f.cy;
   assign ac  = state_next.psw.f.ac;

   // DAA correction, both halves judged on the unadjusted accumulator
   assign lo_fix   = (acc[3:0] > 4'd9) | ac;
   assign hi_fix   = (acc[7:4] > 4'd9) | ((acc[7:4] == 4'd9) & (acc[3:0] > 4'd9)) | cy;
   assign daa_corr = {(hi_fix ? 4'h6 : 4'h0), (lo_fix ? 4'h6 : 4'h0)};

   always_comb
   begin
      case (dec.op)
         OP_ADC:         cin = cy;
         OP_SBB:         cin = ~cy;
         OP_SUB, OP_CMP: cin = 1'b1;
         default:        cin = 1'b0;
      endcase
      // subtracts add the complement
      case (dec.op)
         OP_SUB, OP_SBB, OP_CMP: b_in = ~dec.operand;
         OP_DAA:                 b_in = daa_corr;
         default:                b_in = dec.operand;
      endcase
   end

   // ripple carry chain, chain[4] is the half carry
   always_comb
   begin
      chain[0] = cin;
      for (int i = 0; i < `I8080_DATA_W; i++)
      begin
         add_sum[i]   = acc[i] ^ b_in[i] ^ chain[i];
         chain[i + 1] = (acc[i] & b_in[i]) | (chain[i] & (acc[i] | b_in[i]));
      end
   end

   always_comb
   begin
      res       = acc;
      carry_out = cy;
      case (dec.op)
         OP_ADD, OP_ADC, OP_SUB, OP_SBB, OP_CMP:
         begin
            res       = add_sum;
            carry_out = chain[`I8080_DATA_W];
         end
         OP_DAA:
         begin
            res       = add_sum;
            carry_out = cy | hi_fix;
         end
         OP_ANA: res = acc & dec.operand;
         OP_XRA: res = acc ^ dec.operand;
         OP_ORA: res = acc | dec.operand;
         OP_RLC:
         begin
            res       = {acc[6:0], acc[7]};
            carry_out = acc[7];
         end
         OP_RRC:
         begin
            res       = {acc[0], acc[7:1]};
            carry_out = acc[0];
         end
         // RAL and RAR rotate through the carry
         OP_RAL:
         begin
            res       = {acc[6:0], cy};
            carry_out = acc[7];
         end
         OP_RAR:
         begin
            res       = {cy, acc[7:1]};
            carry_out = acc[0];
         end
         OP_CMA: res = ~acc;
         OP_STC: carry_out = 1'b1;
         OP_CMC: carry_out = ~cy;
         default: res = acc;
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         ex.op     <= OP_NONE;
         ex.sum    <= '0;
         ex.carry7 <= 1'b0;
         ex.carry3 <= 1'b0;
         ex.x3     <= 1'b0;
         ex.r3     <= 1'b0;
         ex.valid  <= 1'b0;
      end
      else
      begin
         ex.op     <= dec.op;
         ex.sum    <= res;
         ex.carry7 <= carry_out;
         ex.carry3 <= chain[4];
         ex.x3     <= dec.operand[3];
         ex.r3     <= acc[3];
         ex.valid  <= dec.valid;
      end
   end

endmodule

// File: logic/flag_commit.sv
// i8080 ALU flag and commit stage
// forms S, Z, AC, P and CY from the execute result, merges them into the
// PSW under a per-operation write mask and holds the accumulator and PSW
`timescale 1ns/1ps
`include "i8080_defines.svh"

module flag_commit
(
   input  logic                             clk,
   input  logic                             reset,
   input  i8080_datapath_pkg::exec_result_t ex,
   output i8080_datapath_pkg::arch_state_t  state,
   output i8080_datapath_pkg::arch_state_t  state_next,
   output logic                             result_valid
);

   import i8080_isa_pkg::*;
   import i8080_datapath_pkg::*;

   psw_u                     new_flags;
   logic [`I8080_DATA_W-1:0] flag_we;
   logic                     acc_we;
   logic                     upd_all;
   logic                     upd_cy;

   always_comb
   begin
      new_flags.f.s     = ex.sum[7];
      new_flags.f.z     = (ex.sum == '0);
      new_flags.f.zero5 = 1'b0;
      new_flags.f.zero3 = 1'b0;
      new_flags.f.p     = ~^ex.sum;
      new_flags.f.one1  = 1'b1;
      new_flags.f.ac    = ex.carry3;
      new_flags.f.cy    = ex.carry7;
      case (ex.op)
         // CY holds the borrow for subtracts
         OP_SUB, OP_SBB, OP_CMP: new_flags.f.cy = ~ex.carry7;
         OP_ANA:
         begin
            new_flags.f.ac = ex.x3 | ex.r3;
            new_flags.f.cy = 1'b0;
         end
         OP_XRA, OP_ORA:
         begin
            new_flags.f.ac = 1'b0;
            new_flags.f.cy = 1'b0;
         end
         default: new_flags.f.cy = ex.carry7;
      endcase
   end

   always_comb
   begin
      acc_we  = 1'b0;
      upd_all = 1'b0;
      upd_cy  = 1'b0;
      case (ex.op)
         OP_ADD, OP_ADC, OP_SUB, OP_SBB, OP_ANA, OP_XRA, OP_ORA, OP_DAA:
         begin
            acc_we  = 1'b1;
            upd_all = 1'b1;
         end
         OP_CMP: upd_all = 1'b1;
         OP_RLC, OP_RRC, OP_RAL, OP_RAR:
         begin
            acc_we = 1'b1;
            upd_cy = 1'b1;
         end
         OP_STC, OP_CMC: upd_cy = 1'b1;
         OP_CMA: acc_we = 1'b1;
         default: acc_we = 1'b0;
      endcase
   end

   // constant PSW bits are never in the mask
   always_comb
   begin
      flag_we                = '0;
      flag_we[`I8080_PSW_S]  = upd_all;
      flag_we[`I8080_PSW_Z]  = upd_all;
      flag_we[`I8080_PSW_AC] = upd_all;
      flag_we[`I8080_PSW_P]  = upd_all;
      flag_we[`I8080_PSW_CY] = upd_all | upd_cy;
   end

   // also the forwarding source for the execute stage
   always_comb
   begin
      state_next = state;
      if (ex.valid)
      begin
         if (acc_we)
            state_next.acc = ex.sum;
         state_next.psw.raw = (state.psw.raw & ~flag_we) | (new_flags.raw & flag_we);
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state.acc     <= '0;
         state.psw.raw <= `I8080_PSW_RESET;
         result_valid  <= 1'b0;
      end
      else
      begin
         state        <= state_next;
         result_valid <= ex.valid;
      end
   end

endmodule

// File: logic/i8080_alu.sv
// i8080 ALU top level
// three-stage pipeline of decode, execute and flag commit with the
// next accumulator state forwarded back into execute
`timescale 1ns/1ps
`include "i8080_defines.svh"

module i8080_alu
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     op_valid,
   input  logic [`I8080_DATA_W-1:0] opcode,
   input  logic [`I8080_DATA_W-1:0] operand,
   output logic                     result_valid,
   output logic [`I8080_DATA_W-1:0] acc,
   output logic [`I8080_DATA_W-1:0] psw
);

   import i8080_isa_pkg::*;
   import i8080_datapath_pkg::*;

   decoded_op_t  dec;
   exec_result_t ex;
   arch_state_t  state;
   arch_state_t  state_next;

   alu_decode u_decode
   (
      .clk      (clk),
      .reset    (reset),
      .op_valid (op_valid),
      .opcode   (opcode),
      .operand  (operand),
      .dec      (dec)
   );

   alu_execute u_execute
   (
      .clk        (clk),
      .reset      (reset),
      .dec        (dec),
      .state_next (state_next),
      .ex         (ex)
   );

   flag_commit u_commit
   (
      .clk          (clk),
      .reset        (reset),
      .ex           (ex),
      .state        (state),
      .state_next   (state_next),
      .result_valid (result_valid)
   );

   assign acc = state.acc;
   assign psw = state.psw.raw;

endmodule

// File: sim/i8080_alu_tb.sv
// testbench for the i8080 ALU pipeline
// checks reset, replays the pattern file one operation at a time, checks
// unsupported opcodes, then runs random back-to-back operations against a model
`timescale 1ns/1ps

module i8080_alu_tb;

   localparam int NUM_PAT   = 21;
   localparam int NUM_ARITH = 10;
   localparam int NUM_RAND  = 200;
   localparam int TIMEOUT   = 20;

   logic        clk;
   logic        reset;
   logic        op_valid;
   logic [7:0]  opcode;
   logic [7:0]  operand;
   logic        result_valid;
   logic [7:0]  acc;
   logic [7:0]  psw;

   // four bytes per pattern in the order opcode, operand, acc, psw
   logic [7:0]  pat_mem [0:4*NUM_PAT-1];
   logic [15:0] exp_q [$];
   logic [15:0] model_st;
   int          checks;
   int          errors;

   i8080_alu UUT
   (
      .clk          (clk),
      .reset        (reset),
      .op_valid     (op_valid),
      .opcode       (opcode),
      .operand      (operand),
      .result_valid (result_valid),
      .acc          (acc),
      .psw          (psw)
   );

   always #10 clk = ~clk;

   task automatic check_val(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic report_test(input int num, input string name, input int err_start);
      $display("test %0d %s: %0d errors", num, name, errors - err_start);
   endtask

   // issue one operation alone and wait for its result strobe
   task automatic issue_and_wait(input logic [7:0] opc, input logic [7:0] opd,
                                 output logic got, output int lat);
      lat = 0;
      @(negedge clk);
      op_valid = 1'b1;
      opcode   = opc;
      operand  = opd;
      @(negedge clk);
      op_valid = 1'b0;
      while (!result_valid && lat < TIMEOUT)
      begin
         @(negedge clk);
         lat++;
      end
      got = result_valid;
      if (!got)
      begin
         $display("Timeout at %0t ns: no result_valid within %0d cycles for opcode %02h",
                  $time, TIMEOUT, opc);
         errors++;
      end
   endtask

   // 8080 accumulator and flag behavior on the state {acc, psw}
   function automatic logic [15:0] model_step(input logic [7:0] opc, input logic [7:0] opd,
                                               input logic [15:0] st);
      logic [7:0] a;
      logic [7:0] f;
      logic [7:0] r;
      logic [7:0] corr;
      logic [2:0] ooo;
      logic       cy;
      logic       ac;
      logic       cin;
      int         wide;
      a   = st[15:8];
      f   = st[7:0];
      ooo = opc[5:3];
      cy  = f[0];
      ac  = 1'b0;
      r   = a;
      if (opc[7:6] == 2'b10 || (opc[7:6] == 2'b11 && opc[2:0] == 3'b110))
      begin
         case (ooo)
            3'd0, 3'd1:
            begin
               cin  = (ooo == 3'd1) ? f[0] : 1'b0;
               wide = a + opd + cin;
               r    = wide[7:0];
               cy   = (wide > 255);
               ac   = (a[3:0] + opd[3:0] + cin > 15);
            end
            3'd2, 3'd3, 3'd7:
            begin
               // CY is the borrow and AC the bit 3 carry of the complement add
               cin  = (ooo == 3'd3) ? f[0] : 1'b0;
               wide = a - opd - cin;
               r    = wide[7:0];
               cy   = (wide < 0);
               ac   = (a[3:0] + (4'hf - opd[3:0]) + (1 - cin) > 15);
            end
            3'd4:
            begin
               r  = a & opd;
               cy = 1'b0;
               ac = a[3] | opd[3];
            end
            3'd5:
            begin
               r  = a ^ opd;
               cy = 1'b0;
            end
            default:
            begin
               r  = a | opd;
               cy = 1'b0;
            end
         endcase
         f = {r[7], (r == 8'h00), 1'b0, ac, 1'b0, ~^r, 1'b1, cy};
         if (ooo != 3'd7)
            a = r;
      end
      else if (opc[7:6] == 2'b00 && opc[2:0] == 3'b111)
      begin
         case (ooo)
            3'd0:
            begin
               f[0] = a[7];
               a    = {a[6:0], a[7]};
            end
            3'd1:
            begin
               f[0] = a[0];
               a    = {a[0], a[7:1]};
            end
            3'd2:
            begin
               cy   = a[7];
               a    = {a[6:0], f[0]};
               f[0] = cy;
            end
            3'd3:
            begin
               cy   = a[0];
               a    = {f[0], a[7:1]};
               f[0] = cy;
            end
            3'd4:
            begin
               // low nibble first and then the high nibble of the partly adjusted value
               corr = (a[3:0] > 4'd9 || f[4]) ? 8'h06 : 8'h00;
               wide = a + corr;
               if ((wide >> 4) > 9 || f[0])
               begin
                  corr = corr + 8'h60;
                  cy   = 1'b1;
               end
               ac = (a[3:0] + corr[3:0] > 15);
               r  = a + corr;
               f  = {r[7], (r == 8'h00), 1'b0, ac, 1'b0, ~^r, 1'b1, cy};
               a  = r;
            end
            3'd5: a = ~a;
            3'd6: f[0] = 1'b1;
            default: f[0] = ~f[0];
         endcase
      end
      return {a, f};
   endfunction

   // register form, immediate form or accumulator group
   function automatic logic [7:0] random_opcode();
      logic [2:0] ooo;
      logic [2:0] sss;
      int         form;
      ooo  = $urandom;
      sss  = $urandom;
      form = $urandom % 3;
      if (form == 0)
         return {2'b10, ooo, sss};
      else if (form == 1)
         return {2'b11, ooo, 3'b110};
      else
         return {2'b00, ooo, 3'b111};
   endfunction

   task automatic run_patterns(input int first, input int last);
      logic got;
      int   lat;
      for (int i = first; i < last; i++)
      begin
         issue_and_wait(pat_mem[4*i], pat_mem[4*i+1], got, lat);
         if (got)
         begin
            check_val($sformatf("pattern %0d acc", i), acc, pat_mem[4*i+2]);
            check_val($sformatf("pattern %0d psw", i), psw, pat_mem[4*i+3]);
            check_val($sformatf("pattern %0d latency", i), lat, 2);
            @(negedge clk);
            check_val($sformatf("pattern %0d result_valid width", i), result_valid, 0);
         end
         model_st = {pat_mem[4*i+2], pat_mem[4*i+3]};
      end
   endtask

   initial
   begin
      int          err_start;
      int          seed_val;
      int          lat;
      int          sent;
      int          recvd;
      int          n;
      logic        got;
      logic [7:0]  opc;
      logic [7:0]  opd;
      logic [7:0]  bad_ops [0:2];
      logic [15:0] e;
      clk      = 1'b0;
      reset    = 1'b1;
      op_valid = 1'b0;
      opcode   = 8'h00;
      operand  = 8'h00;
      checks   = 0;
      errors   = 0;
      seed_val = $urandom(8);
      bad_ops  = '{8'h00, 8'h76, 8'hc3};
      $readmemh("sim/alu_patterns.txt", pat_mem);
      if ($isunknown(pat_mem[0]))
      begin
         $display("Error: pattern file sim/alu_patterns.txt could not be read");
         errors++;
      end
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      err_start = errors;
      repeat (5)
      begin
         @(negedge clk);
         check_val("result_valid while idle", result_valid, 0);
      end
      check_val("acc after reset", acc, 8'h00);
      check_val("psw after reset", psw, 8'h02);
      model_st = 16'h0002;
      report_test(1, "reset state", err_start);

      err_start = errors;
      run_patterns(0, NUM_ARITH);
      report_test(2, "add and subtract patterns", err_start);

      err_start = errors;
      run_patterns(NUM_ARITH, NUM_PAT);
      report_test(3, "logic and accumulator patterns", err_start);

      // unsupported opcodes pass through without touching the state
      err_start = errors;
      for (int i = 0; i < 3; i++)
      begin
         issue_and_wait(bad_ops[i], 8'h5a, got, lat);
         if (got)
         begin
            check_val("acc after unsupported opcode", acc, model_st[15:8]);
            check_val("psw after unsupported opcode", psw, model_st[7:0]);
            check_val("unsupported opcode latency", lat, 2);
         end
      end
      report_test(4, "unsupported opcodes", err_start);

      // back to back with three operations in flight
      err_start = errors;
      sent      = 0;
      recvd     = 0;
      n         = 0;
      while (recvd < NUM_RAND && n < NUM_RAND + TIMEOUT)
      begin
         @(negedge clk);
         n++;
         if (result_valid)
         begin
            if (exp_q.size() == 0)
            begin
               $display("Error at %0t ns: result_valid with no operation pending", $time);
               errors++;
            end
            else
            begin
               e = exp_q.pop_front();
               check_val($sformatf("random op %0d acc", recvd), acc, e[15:8]);
               check_val($sformatf("random op %0d psw", recvd), psw, e[7:0]);
               recvd++;
            end
         end
         if (sent < NUM_RAND)
         begin
            opc      = random_opcode();
            opd      = $urandom;
            model_st = model_step(opc, opd, model_st);
            exp_q.push_back(model_st);
            op_valid = 1'b1;
            opcode   = opc;
            operand  = opd;
            sent++;
         end
         else
            op_valid = 1'b0;
      end
      op_valid = 1'b0;
      if (recvd < NUM_RAND)
      begin
         $display("Timeout at %0t ns: only %0d of %0d random results arrived",
                  $time, recvd, NUM_RAND);
         errors++;
      end
      report_test(5, "random back-to-back", err_start);

      $display("tests 5, checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// File: sim/alu_patterns.txt
// opcode operand expected_acc expected_psw, all hex, replayed in order from reset
// first ten lines are the add and subtract group, the rest logic and accumulator ops
C6 3A 3A 06
81 C8 02 13
CE 05 08 02
D6 09 FF 87
DE 0F EF 82
9A 20 CF 96
FE CF CF 56
B8 D0 CF 97
D6 CF 00 56
CE FF FF 86
E6 5C 5C 16
EE 5C 00 46
B1 81 81 86
07 00 03 87
17 00 07 86
0F 00 83 87
2F 00 7C 87
3F 00 7C 86
37 00 7C 87
C6 1E 9A 96
27 00 00 57

// File: vlog.f
+incdir+logic
logic/i8080_isa_pkg.sv
logic/i8080_datapath_pkg.sv
logic/alu_decode.sv
logic/alu_execute.sv
logic/flag_commit.sv
logic/i8080_alu.sv
sim/i8080_alu_tb.sv

// File: Bender.yml
package:
  name: i8080_alu

sources:
  - include_dirs:
      - logic
    files:
      - logic/i8080_isa_pkg.sv
      - logic/i8080_datapath_pkg.sv
      - logic/alu_decode.sv
      - logic/alu_execute.sv
      - logic/flag_commit.sv
      - logic/i8080_alu.sv
  - target: simulation
    files:
      - sim/i8080_alu_tb.sv
